//--- source/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// APB bus geometry
`define UART_DW           32
`define UART_AW           5

// FIFO sizing, count needs one bit more than the pointer
`define UART_FIFO_DEPTH   16
`define UART_CNT_W        5

// bit-time divisor in clock cycles
`define UART_BAUD_W       16
`define UART_BAUD_DEFAULT 16'd54

// register byte offsets
`define UART_REG_TXDATA   5'h00
`define UART_REG_RXDATA   5'h04
`define UART_REG_RXPOP    5'h08
`define UART_REG_BAUD     5'h0C
`define UART_REG_COUNT    5'h10

`endif

//--- source/uart_pkg.sv
package uart_pkg;

`include "uart_defs.svh"

   typedef logic [7:0] uart_byte_t;                // one serial character
   typedef logic [`UART_CNT_W-1:0] fifo_cnt_t;     // 0 to UART_FIFO_DEPTH
   typedef logic [`UART_BAUD_W-1:0] baud_t;        // cycles per bit

   // transmit sequencer
   typedef enum logic [1:0]
   {
      UTX_IDLE,
      UTX_POP,
      UTX_START,
      UTX_BUSY
   } utx_state_e;

   // register map, values are the byte offsets
   typedef enum logic [`UART_AW-1:0]
   {
      REG_TXDATA = `UART_REG_TXDATA,
      REG_RXDATA = `UART_REG_RXDATA,
      REG_RXPOP  = `UART_REG_RXPOP,
      REG_BAUD   = `UART_REG_BAUD,
      REG_COUNT  = `UART_REG_COUNT
   } uart_reg_e;

endpackage

//--- source/uart_fifo.sv
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_fifo
   import uart_pkg::*;
#(
   parameter int WIDTH = 8
)
(
   input  logic             msoc_clk,
   input  logic             rstn,
   input  logic             push_i,
   input  logic [WIDTH-1:0] data_i,
   input  logic             pop_i,
   output logic [WIDTH-1:0] data_o,
   output fifo_cnt_t        count_o,
   output logic             full_o,
   output logic             empty_o
);

   localparam int PTR_W = $clog2(`UART_FIFO_DEPTH);

   logic [WIDTH-1:0] mem [`UART_FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   fifo_cnt_t        count_q;
   logic             do_push;
   logic             do_pop;

   assign full_o  = (count_q == fifo_cnt_t'(`UART_FIFO_DEPTH));
   assign empty_o = (count_q == '0);
   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;

   assign data_o  = mem[rd_ptr_q];                  // head, fall-through
   assign count_o = count_q;

   always_ff @(posedge msoc_clk)
   begin
      if (do_push)
         mem[wr_ptr_q] <= data_i;
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr_q <= wr_ptr_q + 1'b1;            // wraps at depth
         if (do_pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

//--- source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
   import uart_pkg::*;
(
   input  logic       msoc_clk,
   input  logic       rstn,
   input  baud_t      baud_i,
   input  logic       fifo_empty_i,
   input  uart_byte_t fifo_data_i,
   output logic       fifo_pop_o,
   output logic       tx_o
);

   utx_state_e state_q;
   utx_state_e state_d;
   uart_byte_t byte_q;
   logic [9:0] shift_q;                             // {stop, data, start}
   baud_t      bit_tmr_q;
   logic [3:0] bit_cnt_q;
   logic       bit_end;

   assign bit_end    = (state_q == UTX_BUSY) && (bit_tmr_q == baud_i - baud_t'(1));
   assign fifo_pop_o = (state_q == UTX_POP);
   assign tx_o       = shift_q[0];

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         UTX_IDLE:
            if (!fifo_empty_i)
               state_d = UTX_POP;
         UTX_POP:
            state_d = UTX_START;
         UTX_START:
            state_d = UTX_BUSY;
         UTX_BUSY:
            if (bit_end && (bit_cnt_q == 4'd9))     // end of stop bit
               state_d = UTX_IDLE;
         default:
            state_d = UTX_IDLE;
      endcase
   end

   always_ff @(posedge msoc_clk)
   begin
      if (state_q == UTX_POP)
         byte_q <= fifo_data_i;                     // head popped this cycle
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         state_q   <= UTX_IDLE;
         shift_q   <= '1;                           // line idles high
         bit_tmr_q <= '0;
         bit_cnt_q <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (state_q == UTX_START)
         begin
            shift_q   <= {1'b1, byte_q, 1'b0};
            bit_tmr_q <= '0;
            bit_cnt_q <= '0;
         end
         else if (bit_end)
         begin
            shift_q   <= {1'b1, shift_q[9:1]};      // lsb first, fill with idle
            bit_tmr_q <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
         end
         else if (state_q == UTX_BUSY)
            bit_tmr_q <= bit_tmr_q + 1'b1;
      end
   end

endmodule

//--- source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
   import uart_pkg::*;
(
   input  logic       msoc_clk,
   input  logic       rstn,
   input  logic       rx_i,
   input  baud_t      baud_i,
   output logic       valid_o,
   output uart_byte_t byte_o,
   output logic       frame_err_o
);

   logic [1:0] sync_q;
   logic [2:0] hist_q;                              // last three synced samples
   logic       maj;
   logic       maj_q;
   logic       busy_q;
   baud_t      tmr_q;
   baud_t      tmr_end;
   logic [3:0] bit_cnt_q;                           // 0 start, 1..8 data, 9 stop
   logic       sample;
   uart_byte_t shift_q;
   logic       err_q;
   logic       valid_q;

   assign maj = (hist_q[0] & hist_q[1]) | (hist_q[0] & hist_q[2]) | (hist_q[1] & hist_q[2]);

   // first sample lands mid start bit, then one full bit apart
   assign tmr_end = (bit_cnt_q == 4'd0) ? (baud_i >> 1) - baud_t'(1) : baud_i - baud_t'(1);
   assign sample  = busy_q && (tmr_q == tmr_end);

   assign valid_o     = valid_q;
   assign byte_o      = shift_q;
   assign frame_err_o = err_q;

   always_ff @(posedge msoc_clk)
   begin
      if (sample && (bit_cnt_q >= 4'd1) && (bit_cnt_q <= 4'd8))
         shift_q <= {maj, shift_q[7:1]};
      if (sample && (bit_cnt_q == 4'd9))
         err_q <= ~maj;                             // stop bit must be high
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         sync_q    <= 2'b11;
         hist_q    <= 3'b111;
         maj_q     <= 1'b1;
         busy_q    <= 1'b0;
         tmr_q     <= '0;
         bit_cnt_q <= '0;
         valid_q   <= 1'b0;
      end
      else
      begin
         sync_q  <= {sync_q[0], rx_i};
         hist_q  <= {hist_q[1:0], sync_q[1]};
         maj_q   <= maj;
         valid_q <= 1'b0;
         if (!busy_q)
         begin
            if (maj_q && !maj)                      // falling edge, start bit
            begin
               busy_q    <= 1'b1;
               tmr_q     <= '0;
               bit_cnt_q <= '0;
            end
         end
         else if (sample)
         begin
            tmr_q     <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if ((bit_cnt_q == 4'd0) && maj)
               busy_q <= 1'b0;                      // glitch, not a start bit
            else if (bit_cnt_q == 4'd9)
            begin
               busy_q  <= 1'b0;
               valid_q <= 1'b1;                     // push follows stop sample
            end
         end
         else
            tmr_q <= tmr_q + 1'b1;
      end
   end

endmodule

//--- source/uart_periph.sv
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_periph
   import uart_pkg::*;
(
   input  logic                msoc_clk,
   input  logic                rstn,
   input  logic [`UART_AW-1:0] paddr_i,
   input  logic                psel_i,
   input  logic                penable_i,
   input  logic                pwrite_i,
   input  logic [`UART_DW-1:0] pwdata_i,
   output logic [`UART_DW-1:0] prdata_o,
   output logic                pready_o,
   output logic                pslverr_o,
   input  logic                uart_rx_i,
   output logic                uart_tx_o,
   output logic                uart_irq_o
);

   uart_reg_e  reg_sel;
   logic       access;
   logic       wr_access;
   logic       reg_hit;
   logic       tx_push;
   logic       rx_pop;
   baud_t      baud_q;
   logic       irq_q;

   uart_byte_t tx_head;
   fifo_cnt_t  tx_cnt;
   logic       tx_full;
   logic       tx_empty;
   logic       tx_pop;

   logic [8:0] rx_head;                            // {frame error, byte}
   fifo_cnt_t  rx_cnt;
   logic       rx_full;
   logic       rx_empty;
   logic       rx_valid;
   uart_byte_t rx_byte;
   logic       rx_err;

   assign reg_sel   = uart_reg_e'(paddr_i);
   assign access    = psel_i & penable_i;          // no wait states
   assign wr_access = access & pwrite_i;
   assign pready_o  = 1'b1;

   assign tx_push = wr_access && (reg_sel == REG_TXDATA);
   assign rx_pop  = wr_access && (reg_sel == REG_RXPOP);

   // read word and address decode
   always_comb
   begin
      prdata_o = '0;
      reg_hit  = 1'b1;
      case (reg_sel)
         REG_TXDATA, REG_RXPOP:
            prdata_o = '0;                          // write-only strobes
         REG_RXDATA:
            prdata_o[11:0] = {rx_full, tx_full, rx_empty, rx_head};
         REG_BAUD:
            prdata_o[`UART_BAUD_W-1:0] = baud_q;
         REG_COUNT:
         begin
            prdata_o[8 +: `UART_CNT_W] = tx_cnt;
            prdata_o[0 +: `UART_CNT_W] = rx_cnt;
         end
         default:
            reg_hit = 1'b0;
      endcase
   end

   // unmapped, push into full tx FIFO, pop from empty rx FIFO
   assign pslverr_o = access & (~reg_hit | (tx_push & tx_full) | (rx_pop & rx_empty));

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         baud_q <= `UART_BAUD_DEFAULT;
         irq_q  <= 1'b0;
      end
      else
      begin
         irq_q <= ~rx_empty;                        // one cycle behind the FIFO flag
         if (wr_access && (reg_sel == REG_BAUD))
            baud_q <= pwdata_i[`UART_BAUD_W-1:0];
      end
   end

   assign uart_irq_o = irq_q;

   uart_fifo #(.WIDTH(8)) u_tx_fifo (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .push_i   (tx_push),
      .data_i   (pwdata_i[7:0]),
      .pop_i    (tx_pop),
      .data_o   (tx_head),
      .count_o  (tx_cnt),
      .full_o   (tx_full),
      .empty_o  (tx_empty)
   );

   uart_fifo #(.WIDTH(9)) u_rx_fifo (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .push_i   (rx_valid),                         // lost when full
      .data_i   ({rx_err, rx_byte}),
      .pop_i    (rx_pop),
      .data_o   (rx_head),
      .count_o  (rx_cnt),
      .full_o   (rx_full),
      .empty_o  (rx_empty)
   );

   uart_tx u_tx (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .baud_i       (baud_q),
      .fifo_empty_i (tx_empty),
      .fifo_data_i  (tx_head),
      .fifo_pop_o   (tx_pop),
      .tx_o         (uart_tx_o)
   );

   uart_rx u_rx (
      .msoc_clk    (msoc_clk),
      .rstn        (rstn),
      .rx_i        (uart_rx_i),
      .baud_i      (baud_q),
      .valid_o     (rx_valid),
      .byte_o      (rx_byte),
      .frame_err_o (rx_err)
   );

endmodule

//--- bench/uart_periph_checker.sv
`timescale 1ns/1ps

module uart_periph_checker
   import uart_pkg::*;
(
   input  logic       msoc_clk,
   input  logic       rstn,
   input  logic       psel_i,
   input  logic       penable_i,
   input  logic       pready_i,
   input  logic       pslverr_i,
   input  logic       rx_empty_i,
   input  logic       irq_i,
   input  logic       tx_line_i,
   input  utx_state_e tx_state_i
);

   // no wait states on this slave
   a_pready: assert property (@(posedge msoc_clk) disable iff (!rstn)
      psel_i |-> pready_i)
      else $error("pready low during a selected transfer");

   a_slverr_access: assert property (@(posedge msoc_clk) disable iff (!rstn)
      pslverr_i |-> (psel_i && penable_i))
      else $error("pslverr outside an access cycle");

   a_irq_follows: assert property (@(posedge msoc_clk) disable iff (!rstn)
      $fell(rx_empty_i) |=> irq_i)
      else $error("interrupt did not follow rx FIFO going non-empty");

   a_idle_line: assert property (@(posedge msoc_clk) disable iff (!rstn)
      (tx_state_i == UTX_IDLE) |-> tx_line_i)
      else $error("tx line low while sequencer idle");

endmodule

bind uart_periph uart_periph_checker u_checker (
   .msoc_clk   (msoc_clk),
   .rstn       (rstn),
   .psel_i     (psel_i),
   .penable_i  (penable_i),
   .pready_i   (pready_o),
   .pslverr_i  (pslverr_o),
   .rx_empty_i (rx_empty),
   .irq_i      (uart_irq_o),
   .tx_line_i  (uart_tx_o),
   .tx_state_i (u_tx.state_q)
);

//--- bench/uart_periph_tb.sv
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_periph_tb
   import uart_pkg::*;
();

   localparam int TB_BAUD  = 8;                     // cycles per bit in the test
   localparam int POLL_MAX = 400;
   localparam int OP_WRITE = 0;
   localparam int OP_READ  = 1;
   localparam int OP_PINS  = 2;                     // exp bit 1 is the tx line and bit 0 the irq
   localparam int OP_LOOP  = 3;
   localparam int OP_LOOPR = 4;                     // random byte in loopback
   localparam int OP_WAITC = 5;                     // poll COUNT until it matches
   localparam int OP_FRAME = 6;                     // driven frame with a low stop bit

   logic                msoc_clk = 1'b0;
   logic                rstn;
   logic [`UART_AW-1:0] paddr;
   logic                psel;
   logic                penable;
   logic                pwrite;
   logic [`UART_DW-1:0] pwdata;
   logic [`UART_DW-1:0] prdata;
   logic                pready;
   logic                pslverr;
   logic                uart_rx;
   logic                uart_tx;
   logic                uart_irq;
   logic                loop_en;
   logic                line_drv;

   int                  errors = 0;
   int                  checks = 0;
   int                  timeouts = 0;
   integer              seed = 32'h70ab;

   int                  tbl_op [$];
   logic [4:0]          tbl_off [$];
   logic [31:0]         tbl_wdata [$];
   logic [31:0]         tbl_exp [$];
   logic                tbl_err [$];

   assign uart_rx = loop_en ? uart_tx : line_drv;  // loopback or driven line

   always #20 msoc_clk = ~msoc_clk;

   uart_periph dut_i (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .paddr_i    (paddr),
      .psel_i     (psel),
      .penable_i  (penable),
      .pwrite_i   (pwrite),
      .pwdata_i   (pwdata),
      .prdata_o   (prdata),
      .pready_o   (pready),
      .pslverr_o  (pslverr),
      .uart_rx_i  (uart_rx),
      .uart_tx_o  (uart_tx),
      .uart_irq_o (uart_irq)
   );

   task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("[FAIL] %s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input fifo_cnt_t exp, input fifo_cnt_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("[FAIL] %s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic check_baud(input string name, input baud_t exp, input baud_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("[FAIL] %s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("[FAIL] %s expected %h got %h", name, exp, act);
      end
   endtask

   // one setup cycle, one access cycle, then an idle cycle
   task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      @(negedge msoc_clk);
      paddr   = addr;
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge msoc_clk);
      penable = 1'b1;
      #1;
      rdata = prdata;                               // settled mid access cycle
      err   = pslverr;
      check_bit("pready_o", 1'b1, pready);          // no wait states
      @(negedge msoc_clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [4:0] addr, input logic [31:0] wdata, output logic err);
      logic [31:0] unused;
      apb_xfer(1'b1, addr, wdata, unused, err);
   endtask

   task automatic apb_read(input logic [4:0] addr, output logic [31:0] rdata, output logic err);
      apb_xfer(1'b0, addr, '0, rdata, err);
   endtask

   // field-wise compare of a register read
   task automatic check_read(input logic [4:0] off, input logic [31:0] exp, input logic [31:0] act);
      case (off)
         `UART_REG_BAUD:
            check_baud("baud", exp[15:0], act[15:0]);
         `UART_REG_COUNT:
         begin
            check_count("tx_count", exp[12:8], act[12:8]);
            check_count("rx_count", exp[4:0], act[4:0]);
         end
         `UART_REG_RXDATA:
         begin
            check_bit("rx_full", exp[11], act[11]);
            check_bit("tx_full", exp[10], act[10]);
            check_bit("rx_empty", exp[9], act[9]);
            if (!exp[9])                            // head is only defined when not empty
            begin
               check_bit("rx_err", exp[8], act[8]);
               check_byte("rx_byte", exp[7:0], act[7:0]);
            end
         end
         default:
            ;
      endcase
   endtask

   task automatic wait_rx_data(output logic [31:0] rdata, output logic ok);
      logic err;
      int   n;
      n = 0;
      ok = 1'b0;
      while (!ok && (n < POLL_MAX))
      begin
         apb_read(`UART_REG_RXDATA, rdata, err);
         ok = (rdata[9] === 1'b0);
         n++;
      end
      if (!ok)
      begin
         errors++;
         timeouts++;
         $display("timeout: receive FIFO stayed empty");
      end
   endtask

   task automatic wait_count(input logic [12:0] exp);
      logic [31:0] rdata;
      logic        err;
      int          n;
      n = 0;
      rdata = '0;
      apb_read(`UART_REG_COUNT, rdata, err);
      while ((rdata[12:0] !== exp) && (n < POLL_MAX))
      begin
         apb_read(`UART_REG_COUNT, rdata, err);
         n++;
      end
      if (rdata[12:0] !== exp)
      begin
         errors++;
         timeouts++;
         $display("timeout: FIFO counts never reached the expected values");
      end
   endtask

   // start bit, data lsb first, given stop level, TB_BAUD cycles each
   task automatic drive_frame(input uart_byte_t data, input logic stop);
      logic [9:0] bits;
      int         b;
      bits = {stop, data, 1'b0};
      for (b = 0; b < 10; b++)
      begin
         line_drv = bits[b];
         repeat (TB_BAUD) @(negedge msoc_clk);
      end
      line_drv = 1'b1;
   endtask

   task automatic add_row(input int op, input logic [4:0] off, input logic [31:0] wdata,
                          input logic [31:0] exp, input logic err);
      tbl_op.push_back(op);
      tbl_off.push_back(off);
      tbl_wdata.push_back(wdata);
      tbl_exp.push_back(exp);
      tbl_err.push_back(err);
   endtask

   task automatic build_table();
      // reset values
      add_row(OP_READ,  `UART_REG_BAUD,   0, 32'd54, 1'b0);
      add_row(OP_READ,  `UART_REG_RXDATA, 0, 32'h200, 1'b0);
      add_row(OP_READ,  `UART_REG_COUNT,  0, 32'h000, 1'b0);
      add_row(OP_PINS,  0, 0, 32'h2, 1'b0);
      add_row(OP_WRITE, `UART_REG_BAUD, TB_BAUD, 0, 1'b0);
      add_row(OP_READ,  `UART_REG_BAUD, 0, TB_BAUD, 1'b0);
      // loopback with fixed then random bytes
      add_row(OP_LOOP,  0, 32'h55, 0, 1'b0);
      add_row(OP_LOOP,  0, 32'hA3, 0, 1'b0);
      add_row(OP_LOOP,  0, 32'h00, 0, 1'b0);
      add_row(OP_LOOP,  0, 32'hFF, 0, 1'b0);
      repeat (4) add_row(OP_LOOPR, 0, 0, 0, 1'b0);
      // counts and interrupt with three queued bytes
      add_row(OP_WRITE, `UART_REG_TXDATA, 32'h11, 0, 1'b0);
      add_row(OP_WRITE, `UART_REG_TXDATA, 32'h22, 0, 1'b0);
      add_row(OP_WRITE, `UART_REG_TXDATA, 32'h33, 0, 1'b0);
      add_row(OP_WAITC, `UART_REG_COUNT, 0, 32'h003, 1'b0);
      add_row(OP_PINS,  0, 0, 32'h3, 1'b0);
      add_row(OP_READ,  `UART_REG_RXDATA, 0, 32'h011, 1'b0);
      add_row(OP_WRITE, `UART_REG_RXPOP, 0, 0, 1'b0);
      add_row(OP_READ,  `UART_REG_RXDATA, 0, 32'h022, 1'b0);
      add_row(OP_WRITE, `UART_REG_RXPOP, 0, 0, 1'b0);
      add_row(OP_READ,  `UART_REG_RXDATA, 0, 32'h033, 1'b0);
      add_row(OP_WRITE, `UART_REG_RXPOP, 0, 0, 1'b0);
      add_row(OP_READ,  `UART_REG_COUNT, 0, 32'h000, 1'b0);
      add_row(OP_PINS,  0, 0, 32'h2, 1'b0);
      // framing error and then error responses
      add_row(OP_FRAME, 0, 32'hC5, 32'h1C5, 1'b0);
      add_row(OP_READ,  5'h14, 0, 0, 1'b1);
      add_row(OP_WRITE, `UART_REG_RXPOP, 0, 0, 1'b1);
      add_row(OP_READ,  `UART_REG_BAUD, 0, TB_BAUD, 1'b0);
      add_row(OP_READ,  `UART_REG_COUNT, 0, 32'h000, 1'b0);
      add_row(OP_READ,  `UART_REG_RXDATA, 0, 32'h200, 1'b0);
   endtask

   task automatic apply_row(input int i);
      logic [31:0] rdata;
      logic        err;
      logic        ok;
      uart_byte_t  data;
      case (tbl_op[i])
         OP_WRITE:
         begin
            apb_write(tbl_off[i], tbl_wdata[i], err);
            check_bit("pslverr", tbl_err[i], err);
         end
         OP_READ:
         begin
            apb_read(tbl_off[i], rdata, err);
            check_bit("pslverr", tbl_err[i], err);
            check_read(tbl_off[i], tbl_exp[i], rdata);
         end
         OP_PINS:
         begin
            @(negedge msoc_clk);
            check_bit("uart_irq_o", tbl_exp[i][0], uart_irq);
            check_bit("uart_tx_o", tbl_exp[i][1], uart_tx);
         end
         OP_LOOP, OP_LOOPR:
         begin
            data = (tbl_op[i] == OP_LOOPR) ? uart_byte_t'($random(seed)) : tbl_wdata[i][7:0];
            apb_write(`UART_REG_TXDATA, {24'd0, data}, err);
            check_bit("pslverr", 1'b0, err);
            wait_rx_data(rdata, ok);
            if (ok)
               check_read(`UART_REG_RXDATA, {24'd0, data}, rdata);  // flags clear
            apb_write(`UART_REG_RXPOP, 0, err);
            check_bit("pslverr", 1'b0, err);
         end
         OP_WAITC:
            wait_count(tbl_exp[i][12:0]);
         OP_FRAME:
         begin
            loop_en = 1'b0;
            drive_frame(tbl_wdata[i][7:0], 1'b0);
            wait_rx_data(rdata, ok);
            if (ok)
               check_read(`UART_REG_RXDATA, tbl_exp[i], rdata);
            apb_write(`UART_REG_RXPOP, 0, err);
            check_bit("pslverr", 1'b0, err);
            loop_en = 1'b1;
         end
         default:
            ;
      endcase
   endtask

   initial
   begin
      int i;
      rstn     = 1'b0;
      paddr    = '0;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      pwdata   = '0;
      loop_en  = 1'b1;
      line_drv = 1'b1;                              // idle line level
      build_table();
      repeat (5) @(posedge msoc_clk);
      @(negedge msoc_clk);
      rstn = 1'b1;
      for (i = 0; i < tbl_op.size(); i++)
         apply_row(i);
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

//--- sources.f
+incdir+source
source/uart_pkg.sv
source/uart_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_periph.sv
bench/uart_periph_checker.sv
bench/uart_periph_tb.sv

//--- Bender.yml
package:
  name: uart_periph

sources:
  - include_dirs:
      - source
    files:
      - source/uart_pkg.sv
      - source/uart_fifo.sv
      - source/uart_tx.sv
      - source/uart_rx.sv
      - source/uart_periph.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - bench/uart_periph_checker.sv
      - bench/uart_periph_tb.sv
